//--- verilog/Types.sv
`default_nettype none

package Types;

    // ------------------------------------------------------------
    // Word types
    // ------------------------------------------------------------

    typedef logic [31:0] Data;      // Operand or result word
    typedef logic [31:0] InstAddr;  // PC
    typedef logic [31:0] Inst;      // Instruction word
    typedef logic [11:0] CSRAddr;   // CSR number

    // ------------------------------------------------------------
    // Control encodings
    // ------------------------------------------------------------

    // Operand A source
    typedef enum logic [1:0] {
        A_RS1  = 2'd0,
        A_IMM  = 2'd1,
        A_ZERO = 2'd2,
        A_PC   = 2'd3
    } DataASel;

    // Operand B source, code 3 unused
    typedef enum logic [1:0] {
        B_RS2  = 2'd0,
        B_IMM  = 2'd1,
        B_FOUR = 2'd2
    } DataBSel;

    typedef enum logic {
        RES_ALU = 1'b0,
        RES_CSR = 1'b1
    } ResultSel;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_COPYB = 4'd10   // Pass operand B
    } AluOp;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } CsrOp;

    // ------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------

    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OPIMM  = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] SYSTEM = 7'b1110011;

    // Implemented CSRs
    localparam CSRAddr CSR_MCYCLE   = 12'hB00;
    localparam CSRAddr CSR_MINSTRET = 12'hB02;
    localparam CSRAddr CSR_MSCRATCH = 12'h340;

endpackage

`default_nettype wire

//--- verilog/ALU.sv
`timescale 1ns/100ps
`default_nettype none

module ALU
    import Types::*;
(
    input  AluOp i_op,
    input  Data  i_operandA,
    input  Data  i_operandB,
    output Data  o_result);

    logic [4:0] shamt;                         // Shift amount
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = i_operandB[4:0];
    assign lessSigned   = $signed(i_operandA) < $signed(i_operandB);
    assign lessUnsigned = i_operandA < i_operandB;

    // ------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------

    always_comb begin
        case (i_op)
            ALU_ADD:   o_result = i_operandA + i_operandB;
            ALU_SUB:   o_result = i_operandA - i_operandB;
            ALU_SLL:   o_result = i_operandA << shamt;
            ALU_SLT:   o_result = Data'(lessSigned);
            ALU_SLTU:  o_result = Data'(lessUnsigned);
            ALU_XOR:   o_result = i_operandA ^ i_operandB;
            ALU_SRL:   o_result = i_operandA >> shamt;
            ALU_SRA:   o_result = Data'($signed(i_operandA) >>> shamt);   // Sign fill
            ALU_OR:    o_result = i_operandA | i_operandB;
            ALU_AND:   o_result = i_operandA & i_operandB;
            ALU_COPYB: o_result = i_operandB;
            default:   o_result = '0;          // Unused codes
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/CSRUnit.sv
`timescale 1ns/100ps
`default_nettype none

module CSRUnit
    import Types::*;
(
    input  logic   i_clock,
    input  logic   i_arstN,
    input  logic   i_instRet,      // Legal instruction retiring
    input  CsrOp   i_op,
    input  CSRAddr i_csr,
    input  Data    i_data,         // Write, set or clear mask
    output Data    o_data);        // Value before update

    Data  mcycle;
    Data  minstret;
    Data  mscratch;
    Data  oldValue;
    Data  newValue;
    logic doWrite;

    // ------------------------------------------------------------
    // Read
    // ------------------------------------------------------------

    always_comb begin
        case (i_csr)
            CSR_MCYCLE:   oldValue = mcycle;
            CSR_MINSTRET: oldValue = minstret;
            CSR_MSCRATCH: oldValue = mscratch;
            default:      oldValue = '0;        // Unknown CSR
        endcase
    end

    assign o_data = oldValue;

    // ------------------------------------------------------------
    // Atomic update value
    // ------------------------------------------------------------

    always_comb begin
        case (i_op)
            CSR_SET:   newValue = oldValue | i_data;
            CSR_CLEAR: newValue = oldValue & ~i_data;
            default:   newValue = i_data;          // WRITE
        endcase
    end

    assign doWrite = i_instRet && (i_op != CSR_NONE);

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            mcycle   <= '0;
            minstret <= '0;
            mscratch <= '0;
        end else begin
            // Write replaces this cycle's increment
            if (doWrite && i_csr == CSR_MCYCLE)
                mcycle <= newValue;
            else
                mcycle <= mcycle + 1'b1;

            if (doWrite && i_csr == CSR_MINSTRET)
                minstret <= newValue;
            else if (i_instRet)
                minstret <= minstret + 1'b1;       // Count retired

            if (doWrite && i_csr == CSR_MSCRATCH)
                mscratch <= newValue;
        end
    end

endmodule

`default_nettype wire

//--- verilog/InstDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module InstDecoder
    import Types::*;
(
    input  logic     i_clock,
    input  logic     i_arstN,
    input  logic     i_valid,        // Instruction strobe
    input  Inst      i_inst,
    input  InstAddr  i_pc,
    input  Data      i_dataRS1,
    input  Data      i_dataRS2,
    output logic     o_exValid,      // Strobe into EX
    output Data      o_instIMM,
    output CSRAddr   o_instCSR,
    output DataASel  o_operandASel,
    output DataBSel  o_operandBSel,
    output ResultSel o_resultSel,
    output AluOp     o_aluControl,
    output CsrOp     o_csrControl,
    output logic     o_instRet,      // Legal instruction in EX
    output logic     o_illegal,
    output InstAddr  o_pc,
    output Data      o_dataRS1,
    output Data      o_dataRS2);

    typedef enum logic {IDLE, EXEC} DecodeState;

    DecodeState state;
    logic       legalQ;              // Captured with the payload

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs1;
    logic       altBit;              // inst[30], SUB/SRA select

    // Decoded controls
    Data      imm;
    DataASel  aSel;
    DataBSel  bSel;
    ResultSel resSel;
    AluOp     aluOp;
    CsrOp     csrOp;
    logic     legal;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign rs1    = i_inst[19:15];
    assign funct7 = i_inst[31:25];
    assign altBit = i_inst[30];

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    always_comb begin
        imm    = {{20{i_inst[31]}}, i_inst[31:20]};   // I-type by default
        aSel   = A_RS1;
        bSel   = B_RS2;
        resSel = RES_ALU;
        csrOp  = CSR_NONE;
        legal  = 1'b1;

        // Integer op from funct3, SUB only for OP
        case (funct3)
            3'b000:  aluOp = (opcode == OP && altBit) ? ALU_SUB : ALU_ADD;
            3'b001:  aluOp = ALU_SLL;
            3'b010:  aluOp = ALU_SLT;
            3'b011:  aluOp = ALU_SLTU;
            3'b100:  aluOp = ALU_XOR;
            3'b101:  aluOp = altBit ? ALU_SRA : ALU_SRL;
            3'b110:  aluOp = ALU_OR;
            default: aluOp = ALU_AND;
        endcase

        case (opcode)
            OP: begin
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPIMM: begin
                bSel = B_IMM;
                if (funct3 == 3'b001)
                    legal = (funct7 == 7'b0000000);            // SLLI
                else if (funct3 == 3'b101)
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end
            LUI: begin
                imm   = {i_inst[31:12], 12'b0};                 // U-type
                aSel  = A_ZERO;
                bSel  = B_IMM;
                aluOp = ALU_COPYB;
            end
            AUIPC: begin
                imm   = {i_inst[31:12], 12'b0};
                aSel  = A_PC;
                bSel  = B_IMM;
                aluOp = ALU_ADD;
            end
            JAL, JALR: begin
                if (opcode == JAL)                              // J-type
                    imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                           i_inst[30:21], 1'b0};
                aSel  = A_PC;                                   // Link address
                bSel  = B_FOUR;
                aluOp = ALU_ADD;
                legal = (opcode == JAL) || (funct3 == 3'b000);
            end
            SYSTEM: begin
                imm    = {27'b0, rs1};                          // uimm
                aSel   = funct3[2] ? A_IMM : A_RS1;
                resSel = RES_CSR;
                case (funct3[1:0])
                    2'b01:   csrOp = CSR_WRITE;
                    2'b10:   csrOp = (rs1 == 5'd0) ? CSR_NONE : CSR_SET;
                    2'b11:   csrOp = (rs1 == 5'd0) ? CSR_NONE : CSR_CLEAR;
                    default: legal = 1'b0;                      // ECALL and others
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            state <= IDLE;
        else
            state <= i_valid ? EXEC : IDLE;                     // One cycle in EXEC
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_instIMM     <= imm;
            o_instCSR     <= i_inst[31:20];
            o_operandASel <= aSel;
            o_operandBSel <= bSel;
            o_resultSel   <= resSel;
            o_aluControl  <= aluOp;
            o_csrControl  <= csrOp;
            legalQ        <= legal;
            o_pc          <= i_pc;
            o_dataRS1     <= i_dataRS1;
            o_dataRS2     <= i_dataRS2;
        end
    end

    assign o_exValid = (state == EXEC);
    assign o_instRet = o_exValid && legalQ;
    assign o_illegal = o_exValid && !legalQ;

endmodule

`default_nettype wire

//--- verilog/StageEX.sv
`timescale 1ns/100ps
`default_nettype none

module StageEX
    import Types::*;
(
    input  logic     i_clock,
    input  logic     i_arstN,
    input  logic     i_exValid,      // Instruction in EX
    input  Data      i_instIMM,      // Decoded immediate
    input  Data      i_dataRS1,
    input  Data      i_dataRS2,
    input  CSRAddr   i_instCSR,
    input  InstAddr  i_pc,
    input  DataASel  i_operandASel,
    input  DataBSel  i_operandBSel,
    input  ResultSel i_resultSel,
    input  AluOp     i_aluControl,
    input  CsrOp     i_csrControl,
    input  logic     i_instRet,
    input  logic     i_illegal,
    output logic     o_valid,        // Result strobe
    output logic     o_illegal,
    output Data      o_dataR,        // Result
    output Data      o_dataB);       // RS2 passed on

    Data operandA;
    Data operandB;
    Data aluResult;
    Data csrResult;
    Data result;

    // ------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------

    always_comb begin
        case (i_operandASel)
            A_RS1:   operandA = i_dataRS1;
            A_IMM:   operandA = i_instIMM;     // uimm for CSRxxI
            A_ZERO:  operandA = '0;
            default: operandA = i_pc;
        endcase
    end

    always_comb begin
        case (i_operandBSel)
            B_RS2:   operandB = i_dataRS2;
            B_IMM:   operandB = i_instIMM;
            default: operandB = Data'(4);       // Link offset
        endcase
    end

    // ------------------------------------------------------------
    // Units
    // ------------------------------------------------------------

    ALU aluUnit (
        .i_op       (i_aluControl),
        .i_operandA (operandA),
        .i_operandB (operandB),
        .o_result   (aluResult));

    // Operand A doubles as CSR write data
    CSRUnit csrUnit (
        .i_clock   (i_clock),
        .i_arstN   (i_arstN),
        .i_instRet (i_instRet),
        .i_op      (i_csrControl),
        .i_csr     (i_instCSR),
        .i_data    (operandA),
        .o_data    (csrResult));

    assign result = (i_resultSel == RES_CSR) ? csrResult : aluResult;

    // ------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
        end else begin
            o_valid   <= i_exValid;
            o_illegal <= i_illegal;            // Already qualified by exValid
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_exValid) begin
            o_dataR <= result;
            o_dataB <= i_dataRS2;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ExecPipe.sv
`timescale 1ns/100ps
`default_nettype none

module ExecPipe
    import Types::*;
(
    input  logic    i_clock,
    input  logic    i_arstN,
    input  logic    i_valid,
    input  Inst     i_inst,
    input  InstAddr i_pc,
    input  Data     i_dataRS1,
    input  Data     i_dataRS2,
    output logic    o_valid,       // Two cycles after i_valid
    output logic    o_illegal,
    output Data     o_dataR,
    output Data     o_dataB);

    // ------------------------------------------------------------
    // Decode to EX
    // ------------------------------------------------------------

    logic     exValid;
    Data      instIMM;
    CSRAddr   instCSR;
    DataASel  operandASel;
    DataBSel  operandBSel;
    ResultSel resultSel;
    AluOp     aluControl;
    CsrOp     csrControl;
    logic     instRet;
    logic     illegal;
    InstAddr  pc;
    Data      dataRS1;
    Data      dataRS2;

    InstDecoder instDecoder (
        .i_clock       (i_clock),
        .i_arstN       (i_arstN),
        .i_valid       (i_valid),
        .i_inst        (i_inst),
        .i_pc          (i_pc),
        .i_dataRS1     (i_dataRS1),
        .i_dataRS2     (i_dataRS2),
        .o_exValid     (exValid),
        .o_instIMM     (instIMM),
        .o_instCSR     (instCSR),
        .o_operandASel (operandASel),
        .o_operandBSel (operandBSel),
        .o_resultSel   (resultSel),
        .o_aluControl  (aluControl),
        .o_csrControl  (csrControl),
        .o_instRet     (instRet),
        .o_illegal     (illegal),
        .o_pc          (pc),
        .o_dataRS1     (dataRS1),
        .o_dataRS2     (dataRS2));

    StageEX stageEX (
        .i_clock       (i_clock),
        .i_arstN       (i_arstN),
        .i_exValid     (exValid),
        .i_instIMM     (instIMM),
        .i_dataRS1     (dataRS1),
        .i_dataRS2     (dataRS2),
        .i_instCSR     (instCSR),
        .i_pc          (pc),
        .i_operandASel (operandASel),
        .i_operandBSel (operandBSel),
        .i_resultSel   (resultSel),
        .i_aluControl  (aluControl),
        .i_csrControl  (csrControl),
        .i_instRet     (instRet),
        .i_illegal     (illegal),
        .o_valid       (o_valid),
        .o_illegal     (o_illegal),
        .o_dataR       (o_dataR),
        .o_dataB       (o_dataB));

endmodule

`default_nettype wire

//--- verification/ExecPipe_checker.sv
`timescale 1ns/100ps
`default_nettype none

module ExecPipeChecker (
    input  logic i_clock,
    input  logic i_arstN,
    input  logic i_valid,           // Instruction strobe
    input  logic i_outValid,        // Result strobe
    input  logic i_outIllegal);

    int failCount = 0;              // Read by the testbench at the end

    // ------------------------------------------------------------
    // Strobe timing
    // ------------------------------------------------------------

    // Fixed two-cycle latency, in both directions
    validLatency: assert property (@(posedge i_clock) disable iff (!i_arstN)
        i_outValid == $past(i_valid, 2))
        else begin
            failCount++;
            $error("o_valid does not follow i_valid by exactly two cycles");
        end

    illegalQualified: assert property (@(posedge i_clock) disable iff (!i_arstN)
        i_outIllegal |-> i_outValid)
        else begin
            failCount++;
            $error("o_illegal raised without o_valid");
        end

    // Outputs quiet while in reset
    resetQuiet: assert property (@(posedge i_clock)
        !i_arstN |-> (!i_outValid && !i_outIllegal))
        else begin
            failCount++;
            $error("o_valid or o_illegal high during reset");
        end

endmodule

bind ExecPipe ExecPipeChecker execChecker (
    .i_clock      (i_clock),
    .i_arstN      (i_arstN),
    .i_valid      (i_valid),
    .i_outValid   (o_valid),
    .i_outIllegal (o_illegal));

`default_nettype wire

//--- verification/ExecMonitor.sv
`timescale 1ns/100ps
`default_nettype none

module ExecMonitor
    import Types::*;
(
    input  logic    i_clock,
    input  logic    i_arstN,
    input  logic    i_valid,        // DUT inputs
    input  Inst     i_inst,
    input  InstAddr i_pc,
    input  Data     i_dataRS1,
    input  Data     i_dataRS2,
    input  logic    i_outValid,     // DUT outputs
    input  logic    i_outIllegal,
    input  Data     i_dataR,
    input  Data     i_dataB,
    output int      o_checks,
    output int      o_errors,
    output int      o_pending);     // Results still expected

    Inst     instQ[$];
    InstAddr pcQ[$];
    Data     rs1Q[$];
    Data     rs2Q[$];
    Data     cycleQ[$];             // Clock count at the strobe edge

    Data cycles;                    // Clocks since reset release
    Data mscratch;
    Data minstret;
    Data mcycleOffset;              // mcycle minus clock count
    int  checks = 0;
    int  errors = 0;
    int  pending = 0;

    assign o_checks  = checks;
    assign o_errors  = errors;
    assign o_pending = pending;

    // ------------------------------------------------------------
    // Reference model, ISA rules plus CSR state
    // ------------------------------------------------------------

    // Returns {illegal, result} and advances the CSR model
    function automatic logic [32:0] reference(Inst inst, InstAddr pc, Data rs1, Data rs2,
                                              Data cyc);
        logic [6:0] opcode;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rs1Field;
        CSRAddr     csr;
        Data        immU;
        Data        b;
        Data        src;
        Data        old;
        Data        upd;
        Data        result;
        logic       legal;
        logic       doWrite;

        opcode   = inst[6:0];
        f3       = inst[14:12];
        f7       = inst[31:25];
        rs1Field = inst[19:15];
        csr      = inst[31:20];
        immU     = {inst[31:12], 12'b0};
        b        = (opcode == OP) ? rs2 : {{20{inst[31]}}, inst[31:20]};
        result   = '0;
        legal    = 1'b1;
        doWrite  = 1'b0;
        upd      = '0;

        case (opcode)
            OP, OPIMM: begin
                if (opcode == OP)
                    legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                else if (f3 == 3'd1)
                    legal = (f7 == 7'h00);                          // SLLI
                else if (f3 == 3'd5)
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                case (f3)
                    3'd0: result = (opcode == OP && f7[5]) ? rs1 - b : rs1 + b;
                    3'd1: result = rs1 << b[4:0];
                    3'd2: result = {31'b0, $signed(rs1) < $signed(b)};
                    3'd3: result = {31'b0, rs1 < b};
                    3'd4: result = rs1 ^ b;
                    3'd5: begin
                        if (f7[5])
                            result = $signed(rs1) >>> b[4:0];       // Arithmetic
                        else
                            result = rs1 >> b[4:0];
                    end
                    3'd6: result = rs1 | b;
                    default: result = rs1 & b;
                endcase
            end
            LUI:   result = immU;
            AUIPC: result = pc + immU;
            JAL:   result = pc + 32'd4;                             // Link address
            JALR: begin
                result = pc + 32'd4;
                legal  = (f3 == 3'd0);
            end
            SYSTEM: begin
                legal = (f3[1:0] != 2'b00);                         // ECALL and others
                src   = f3[2] ? {27'b0, rs1Field} : rs1;
                case (csr)
                    CSR_MCYCLE:   old = cyc + 32'd1 + mcycleOffset; // Value at EX edge
                    CSR_MINSTRET: old = minstret;
                    CSR_MSCRATCH: old = mscratch;
                    default:      old = '0;
                endcase
                result  = old;
                doWrite = legal && (f3[1:0] == 2'b01 || rs1Field != 5'd0);
                case (f3[1:0])
                    2'b10:   upd = old | src;
                    2'b11:   upd = old & ~src;
                    default: upd = src;
                endcase
            end
            default: legal = 1'b0;
        endcase

        if (legal && !(doWrite && csr == CSR_MINSTRET))
            minstret = minstret + 32'd1;                            // Retired
        if (doWrite && csr == CSR_MSCRATCH)
            mscratch = upd;
        if (doWrite && csr == CSR_MINSTRET)
            minstret = upd;
        if (doWrite && csr == CSR_MCYCLE)
            mcycleOffset = upd - cyc - 32'd2;                       // Holds upd next cycle
        return {~legal, result};
    endfunction

    // ------------------------------------------------------------
    // Clock count and comparison
    // ------------------------------------------------------------

    always @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            cycles <= '0;
        else
            cycles <= cycles + 32'd1;
    end

    always @(posedge i_clock or negedge i_arstN) begin : compare
        logic [32:0] expected;
        Inst         inst;
        Data         rs2;

        if (!i_arstN) begin
            instQ.delete();
            pcQ.delete();
            rs1Q.delete();
            rs2Q.delete();
            cycleQ.delete();
            mscratch     = '0;
            minstret     = '0;
            mcycleOffset = '0;
        end else begin
            // Pop before push, the new strobe is never the one retiring
            if (i_outValid && instQ.size() == 0) begin
                errors++;
                $display("Result strobe at %0t with no instruction outstanding", $time);
            end else if (i_outValid) begin
                inst     = instQ[0];
                rs2      = rs2Q[0];
                expected = reference(inst, pcQ[0], rs1Q[0], rs2, cycleQ[0]);
                void'(instQ.pop_front());
                void'(pcQ.pop_front());
                void'(rs1Q.pop_front());
                void'(rs2Q.pop_front());
                void'(cycleQ.pop_front());
                checks++;
                if (i_outIllegal !== expected[32]) begin
                    errors++;
                    $display("Fail o_illegal: got %h, expected %h, inst %h",
                             i_outIllegal, expected[32], inst);
                end
                if (!expected[32] && i_dataR !== expected[31:0]) begin
                    errors++;
                    $display("Fail o_dataR: got %h, expected %h, inst %h",
                             i_dataR, expected[31:0], inst);
                end
                if (i_dataB !== rs2) begin
                    errors++;
                    $display("Fail o_dataB: got %h, expected %h, inst %h", i_dataB, rs2, inst);
                end
            end
            if (i_valid) begin
                instQ.push_back(i_inst);
                pcQ.push_back(i_pc);
                rs1Q.push_back(i_dataRS1);
                rs2Q.push_back(i_dataRS2);
                cycleQ.push_back(cycles);                           // Old value, pre-edge
            end
        end
        pending = instQ.size();
    end

endmodule

`default_nettype wire

//--- verification/ExecPipeTb.sv
`timescale 1ns/100ps
`default_nettype none

module ExecPipeTb
    import Types::*;
();

    logic    clock;
    logic    arstN;
    logic    valid;
    Inst     inst;
    InstAddr pc;
    Data     dataRS1;
    Data     dataRS2;
    logic    outValid;
    logic    outIllegal;
    Data     dataR;
    Data     dataB;
    int      checks;
    int      errors;
    int      pending;
    int      sent = 0;
    int      timeouts = 0;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;                 // 20 ns period
    end

    ExecPipe i_ExecPipe (
        .i_clock   (clock),
        .i_arstN   (arstN),
        .i_valid   (valid),
        .i_inst    (inst),
        .i_pc      (pc),
        .i_dataRS1 (dataRS1),
        .i_dataRS2 (dataRS2),
        .o_valid   (outValid),
        .o_illegal (outIllegal),
        .o_dataR   (dataR),
        .o_dataB   (dataB));

    ExecMonitor execMonitor (
        .i_clock      (clock),
        .i_arstN      (arstN),
        .i_valid      (valid),
        .i_inst       (inst),
        .i_pc         (pc),
        .i_dataRS1    (dataRS1),
        .i_dataRS2    (dataRS2),
        .i_outValid   (outValid),
        .i_outIllegal (outIllegal),
        .i_dataR      (dataR),
        .i_dataB      (dataB),
        .o_checks     (checks),
        .o_errors     (errors),
        .o_pending    (pending));

    // ------------------------------------------------------------
    // Encoders and drivers
    // ------------------------------------------------------------

    function automatic Inst rType(logic [6:0] f7, logic [2:0] f3, logic [6:0] opcode);
        return {f7, 5'd2, 5'd3, f3, 5'd1, opcode};  // rd x1, rs1 x3, rs2 x2
    endfunction

    function automatic Inst iType(logic [11:0] imm, logic [4:0] rs1f, logic [2:0] f3,
                                  logic [6:0] opcode);
        return {imm, rs1f, f3, 5'd1, opcode};
    endfunction

    function automatic Inst uType(logic [19:0] imm, logic [6:0] opcode);
        return {imm, 5'd1, opcode};                 // Also JAL, bits scrambled anyway
    endfunction

    // One strobe with random operands, starts and ends on a falling edge
    task automatic sendInst(input Inst instWord);
        inst    = instWord;
        pc      = $urandom & 32'hFFFF_FFFC;
        dataRS1 = $urandom;
        dataRS2 = $urandom;
        valid   = 1'b1;
        sent++;
        @(negedge clock);
        valid   = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clock);
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        while (pending != 0 && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (pending != 0) begin
            timeouts++;
            $display("Timed out waiting for o_valid with %0d results outstanding", pending);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [4:0]  rs1f;
        CSRAddr      csr;

        void'($urandom(79928));
        arstN    = 1'b0;
        valid    = 1'b0;
        inst     = '0;
        pc       = '0;
        dataRS1  = '0;
        dataRS2  = '0;
        repeat (3) @(negedge clock);                // Reset for 3 cycles
        arstN = 1'b1;
        @(negedge clock);

        // OP and OP-IMM over every funct3, both SUB/SRA forms
        repeat (300) begin
            f3  = 3'($urandom);
            f7  = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            imm = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5)
                imm[11:5] = f7;                     // Legal shift encodings
            if ($urandom_range(0, 1) == 0)
                sendInst(rType(f7, f3, OP));
            else
                sendInst(iType(imm, 5'd3, f3, OPIMM));
            idle($urandom_range(0, 2));
        end
        drain();

        // Upper immediates and links
        repeat (40) begin
            sendInst(uType(20'($urandom), LUI));
            sendInst(uType(20'($urandom), AUIPC));
            sendInst(uType(20'($urandom), JAL));
            sendInst(iType(12'($urandom), 5'($urandom), 3'd0, JALR));
            idle($urandom_range(0, 2));
        end
        drain();

        // mscratch, rs1 field zero a quarter of the time
        repeat (80) begin
            f3 = 3'($urandom);
            if (f3[1:0] == 2'b00)
                f3[0] = 1'b1;
            rs1f = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
            sendInst(iType(CSR_MSCRATCH, rs1f, f3, SYSTEM));
            idle($urandom_range(0, 1));
        end
        drain();

        // Counter reads around illegal encodings
        repeat (40) begin
            sendInst(iType(CSR_MINSTRET, 5'd0, 3'b010, SYSTEM));
            sendInst(rType(7'h01, 3'($urandom), OP));       // M extension, not decoded
            sendInst(iType(CSR_MCYCLE, 5'd0, 3'b010, SYSTEM));
            sendInst(iType(12'h000, 5'd0, 3'd0, SYSTEM));   // ECALL
            idle($urandom_range(0, 3));
        end
        drain();

        // Back to back, all CSRs and unknown ones, writes included
        repeat (200) begin
            case ($urandom_range(0, 3))
                0:       csr = CSR_MINSTRET;
                1:       csr = CSR_MCYCLE;
                2:       csr = CSR_MSCRATCH;
                default: csr = 12'($urandom);
            endcase
            f3 = 3'($urandom);
            if ($urandom_range(0, 2) == 0)
                sendInst(rType(7'h00, f3, OP));
            else
                sendInst(iType(csr, 5'($urandom), f3, SYSTEM));
        end
        drain();

        $display("Sent %0d  checked %0d  errors %0d  timeouts %0d  assertion failures %0d",
                 sent, checks, errors, timeouts, i_ExecPipe.execChecker.failCount);
        if (errors == 0 && timeouts == 0 && checks == sent &&
            i_ExecPipe.execChecker.failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/Types.sv
verilog/ALU.sv
verilog/CSRUnit.sv
verilog/InstDecoder.sv
verilog/StageEX.sv
verilog/ExecPipe.sv
verification/ExecPipe_checker.sv
verification/ExecMonitor.sv
verification/ExecPipeTb.sv

//--- run.sh
#!/bin/sh
# Compile the execute-stage testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module ExecPipeTb -Mdir obj_dir -f project.f \
    && ./obj_dir/VExecPipeTb +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Build or simulation did not complete" >> sim.log

cat sim.log

# Pass only when the testbench printed its pass line
grep -q "^Test OK$" sim.log && exit 0 || exit 1
